//--- hw/mmult_consts.svh
// Data sizes, memory sizes, host address map and MMULT opcode value
`ifndef MMULT_CONSTS_SVH
`define MMULT_CONSTS_SVH

// Datapath word width
`define MMULT_DATA_W 32
// Matrix word address width, byte address bits 11:2
`define MMULT_ADDR_W 10
// Matrix RAM size in words
`define MMULT_MTX_DEPTH 64
// General register count
`define MMULT_REG_COUNT 32

// Bits 15:10 of an MMULT instruction
`define MMULT_OPCODE 6'b110110

// Host byte address map
`define MMULT_MTXC_ADDR 'h000
`define MMULT_MTXA_ADDR 'h004
`define MMULT_RAM_BASE 'h400
`define MMULT_REG_BASE 'h800

`endif

//--- hw/mmult_isa_pkg.sv
// Instruction format, opcode enum and internal systolic operation types
`include "mmult_consts.svh"

package mmult_isa_pkg;

	// Major opcode, only MMULT is executed here
	typedef enum logic [5:0] {
		OTHER = 6'b000000,
		MMULT = `MMULT_OPCODE
	} opcode_e;

	// 16-bit instruction word: op, source row register, destination
	typedef struct packed {
		opcode_e op;
		logic [4:0] rs;
		logic [4:0] rd;
	} instr_t;

	// Internal operations issued per sequencer step
	typedef enum logic [1:0] {
		NOP = 2'd0,
		IMULTN = 2'd1,
		IMACN = 2'd2,
		RESMAC = 2'd3
	} sys_op_e;

	// Internal instruction passed to the datapath
	typedef struct packed {
		sys_op_e op;
		logic [4:0] src;
		logic [4:0] dst;
		// Selects the high half of src when set
		logic half;
	} sys_ins_t;

endpackage

//--- hw/mmult_bus_pkg.sv
// Host bus response, matrix control register and address region types
package mmult_bus_pkg;

	// AXI4-Lite response codes used by the host port
	typedef enum logic [1:0] {
		OKAY = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

	// MTXC: address-width flag above the 4-bit row width
	typedef struct packed {
		logic addw;
		logic [3:0] width;
	} mtxc_t;

	// Decoded host address regions
	typedef enum logic [2:0] {
		MTXC,
		MTXA,
		RAM,
		REG,
		NONE
	} host_region_e;

endpackage

//--- hw/mtx_bus_if.sv
// Matrix memory bus between sequencer, matrix RAM and datapath
`timescale 1ns/1ps
`include "mmult_consts.svh"

interface mtx_bus_if;
	// Request and word address from the sequencer
	logic mreq;
	logic [`MMULT_ADDR_W-1:0] addr;
	// Data phase outstanding
	logic dover;
	// One-cycle data acknowledge with the read word
	logic datack;
	logic [`MMULT_DATA_W-1:0] rdata;

	modport seq (output mreq, output addr, output dover, input datack, input rdata);

	modport ram (input mreq, input addr, input dover, output datack, output rdata);

	// Datapath only samples the returned word
	modport dp (input datack, input rdata);
endinterface

//--- hw/sys_ins_if.sv
// Internal instruction link from the systolic sequencer to the MAC datapath
`timescale 1ns/1ps

interface sys_ins_if;
	// Current internal instruction
	mmult_isa_pkg::sys_ins_t ins;
	// Half select for the operation now in execute
	logic multsel;
	// Retires ins and advances the sequencer
	logic step;
	// Matrix data not yet returned
	logic stall;

	modport seq (output ins, output multsel, output stall, input step);

	modport dp (input ins, input multsel, input stall, output step);
endinterface

//--- hw/mmult_host_regs.sv
// AXI4-Lite slave with address decode for MTXC, MTXA, matrix RAM and registers
`timescale 1ns/1ps
`include "mmult_consts.svh"

module mmult_host_regs (
	input logic sys_clk,
	input logic resetl,
	input logic [`MMULT_ADDR_W+1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [`MMULT_DATA_W-1:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output mmult_bus_pkg::axi_resp_e bresp,
	output logic bvalid,
	input logic bready,
	input logic [`MMULT_ADDR_W+1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [`MMULT_DATA_W-1:0] rdata,
	output mmult_bus_pkg::axi_resp_e rresp,
	output logic rvalid,
	input logic rready,
	input logic busy,
	output logic mtxc_wr,
	output logic mtxa_wr,
	output logic [`MMULT_DATA_W-1:0] reg_wdata,
	input mmult_bus_pkg::mtxc_t mtxc,
	input logic [`MMULT_ADDR_W-1:0] mtxa,
	output logic host_we,
	output logic host_re,
	output logic [`MMULT_ADDR_W-1:0] host_addr,
	output logic [`MMULT_DATA_W-1:0] host_wdata,
	input logic [`MMULT_DATA_W-1:0] host_rdata,
	output logic rf_we,
	output logic [4:0] rf_addr,
	output logic [`MMULT_DATA_W-1:0] rf_wdata,
	input logic [`MMULT_DATA_W-1:0] rf_rdata
);
	localparam int AW = `MMULT_ADDR_W + 2;
	localparam logic [AW-1:0] MTXC_A = AW'(`MMULT_MTXC_ADDR);
	localparam logic [AW-1:0] MTXA_A = AW'(`MMULT_MTXA_ADDR);
	localparam logic [AW-1:0] RAM_LO = AW'(`MMULT_RAM_BASE);
	localparam logic [AW-1:0] RAM_HI = AW'(`MMULT_RAM_BASE + 4 * `MMULT_MTX_DEPTH);
	localparam logic [AW-1:0] REG_LO = AW'(`MMULT_REG_BASE);
	localparam logic [AW-1:0] REG_HI = AW'(`MMULT_REG_BASE + 4 * `MMULT_REG_COUNT);

	logic aw_full;
	logic w_full;
	logic rd_pend;
	logic [AW-1:0] aw_q;
	logic [`MMULT_DATA_W-1:0] w_q;
	logic [3:0] s_q;
	logic aw_take;
	logic w_take;
	logic ar_take;
	logic wr_go;
	logic [AW-1:0] wr_addr;
	logic [AW-1:0] sel_addr;
	logic [AW-1:0] ram_off;
	logic [AW-1:0] reg_off;
	logic [`MMULT_DATA_W-1:0] wr_data;
	logic [3:0] wr_strb;
	mmult_bus_pkg::host_region_e wr_region;
	mmult_bus_pkg::host_region_e rd_region;
	logic wr_ok;
	logic rd_ok;
	logic [`MMULT_DATA_W-1:0] rd_word;

	// Map a byte address onto its region
	function automatic mmult_bus_pkg::host_region_e decode(input logic [AW-1:0] a);
		if (a[AW-1:2] == MTXC_A[AW-1:2])
			return mmult_bus_pkg::MTXC;
		if (a[AW-1:2] == MTXA_A[AW-1:2])
			return mmult_bus_pkg::MTXA;
		if (a >= RAM_LO && a < RAM_HI)
			return mmult_bus_pkg::RAM;
		if (a >= REG_LO && a < REG_HI)
			return mmult_bus_pkg::REG;
		return mmult_bus_pkg::NONE;
	endfunction

	// Address and data may arrive apart, both stall while a response waits
	assign awready = ~aw_full & ~bvalid;
	assign wready = ~w_full & ~bvalid;
	assign aw_take = awvalid & awready;
	assign w_take = wvalid & wready;
	assign wr_addr = aw_full ? aw_q : awaddr;
	assign wr_data = w_full ? w_q : wdata;
	assign wr_strb = w_full ? s_q : wstrb;
	// Write fires in the cycle its second half is taken
	assign wr_go = (aw_full | aw_take) & (w_full | w_take);

	// Writes own the shared strobes, so a read waits out that cycle
	assign arready = ~rvalid & ~rd_pend & ~wr_go;
	assign ar_take = arvalid & arready;

	assign wr_region = decode(wr_addr);
	assign rd_region = decode(araddr);
	// Only full-word writes, and no RAM access while the sequencer owns it
	assign wr_ok = (wr_region != mmult_bus_pkg::NONE) && (wr_strb == 4'hf) &&
		!(wr_region == mmult_bus_pkg::RAM && busy);
	assign rd_ok = (rd_region != mmult_bus_pkg::NONE) &&
		!(rd_region == mmult_bus_pkg::RAM && busy);

	// Region offsets from the address in use this cycle
	assign sel_addr = wr_go ? wr_addr : araddr;
	assign ram_off = sel_addr - RAM_LO;
	assign reg_off = sel_addr - REG_LO;
	assign host_addr = ram_off[AW-1:2];
	assign rf_addr = reg_off[6:2];

	// One strobe per accepted transaction
	assign mtxc_wr = wr_go && wr_ok && (wr_region == mmult_bus_pkg::MTXC);
	assign mtxa_wr = wr_go && wr_ok && (wr_region == mmult_bus_pkg::MTXA);
	assign host_we = wr_go && wr_ok && (wr_region == mmult_bus_pkg::RAM);
	assign rf_we = wr_go && wr_ok && (wr_region == mmult_bus_pkg::REG);
	assign host_re = ar_take && rd_ok && (rd_region == mmult_bus_pkg::RAM);
	assign reg_wdata = wr_data;
	assign host_wdata = wr_data;
	assign rf_wdata = wr_data;

	// Register readback, MTXA returned as a byte address
	always_comb begin
		case (rd_region)
			mmult_bus_pkg::MTXC: rd_word = {{(`MMULT_DATA_W - 5){1'b0}}, mtxc};
			mmult_bus_pkg::MTXA: rd_word = {{(`MMULT_DATA_W - AW){1'b0}}, mtxa, 2'b00};
			mmult_bus_pkg::REG: rd_word = rf_rdata;
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			aw_full <= 1'b0;
			w_full <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			rd_pend <= 1'b0;
		end else begin
			if (wr_go) begin
				aw_full <= 1'b0;
				w_full <= 1'b0;
			end else begin
				if (aw_take)
					aw_full <= 1'b1;
				if (w_take)
					w_full <= 1'b1;
			end
			if (wr_go)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			// RAM word appears a cycle after host_re
			rd_pend <= host_re;
			if (rd_pend || (ar_take && !host_re))
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (aw_take)
			aw_q <= awaddr;
		if (w_take) begin
			w_q <= wdata;
			s_q <= wstrb;
		end
		if (wr_go)
			bresp <= wr_ok ? mmult_bus_pkg::OKAY : mmult_bus_pkg::SLVERR;
		// Capture the read word so it holds until rready
		if (rd_pend) begin
			rdata <= host_rdata;
			rresp <= mmult_bus_pkg::OKAY;
		end else if (ar_take) begin
			rdata <= rd_word;
			rresp <= rd_ok ? mmult_bus_pkg::OKAY : mmult_bus_pkg::SLVERR;
		end
	end

	// Write response stays up and unchanged until the master takes it
	a_bvalid_hold: assert property (@(posedge sys_clk) disable iff (!resetl)
		bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

//--- hw/systolic_seq.sv
// MMULT sequencer: matrix control registers, step FSM, row counter, matrix requests
`timescale 1ns/1ps
`include "mmult_consts.svh"

module systolic_seq (
	input logic sys_clk,
	input logic resetl,
	input logic instr_valid,
	input mmult_isa_pkg::instr_t instr,
	output logic busy,
	input logic mtxc_wr,
	input logic mtxa_wr,
	input logic [`MMULT_DATA_W-1:0] wdata,
	output mmult_bus_pkg::mtxc_t mtxc,
	output logic [`MMULT_ADDR_W-1:0] mtxa,
	mtx_bus_if.seq mtx,
	sys_ins_if.seq sys
);
	typedef enum logic [1:0] {
		IDLE,
		MULT,
		MAC,
		RES
	} state_e;

	state_e state;
	// Steps left, 0 stands for 16
	logic [3:0] count;
	// Row element pointer as {register, half}
	logic [5:0] row;
	logic [4:0] dst;
	logic dover;
	logic mreq;
	logic accept;
	logic step;
	logic [4:0] n_val;
	logic [`MMULT_ADDR_W-1:0] stride;

	assign busy = (state != IDLE);
	assign step = sys.step;
	// Non-MMULT opcodes are taken and dropped
	assign accept = instr_valid && !busy && (instr.op == mmult_isa_pkg::MMULT);

	// Width 0 wraps to 16
	assign n_val = {mtxc.width == 4'd0, mtxc.width};
	assign stride = mtxc.addw ? {{(`MMULT_ADDR_W - 5){1'b0}}, n_val} : `MMULT_ADDR_W'(1);

	// Control registers and column address
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			mtxc <= '0;
			mtxa <= '0;
		end else begin
			if (mtxc_wr)
				mtxc <= mmult_bus_pkg::mtxc_t'(wdata[4:0]);
			if (mtxa_wr)
				mtxa <= wdata[`MMULT_ADDR_W+1:2];
			else if (dover && mtx.datack)
				mtxa <= mtxa + stride;
		end
	end

	// IMULTN, N-1 IMACN, RESMAC
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (accept)
						state <= MULT;
				end
				MULT, MAC: begin
					if (step)
						state <= (count == 4'd1) ? RES : MAC;
				end
				RES: begin
					if (step)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Width counter and row pointer move once per step
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			count <= 4'd0;
			row <= 6'd0;
			sys.multsel <= 1'b0;
		end else if (accept) begin
			count <= mtxc.width;
			row <= {instr.rs, 1'b0};
		end else if (step) begin
			count <= count - 4'd1;
			row <= row + 6'd1;
			// Half select follows the operation into execute
			sys.multsel <= sys.ins.half;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept)
			dst <= instr.rd;
	end

	// New request per multiply step, held over a waited data phase
	assign mreq = (state == MULT) || (state == MAC) || (dover && !mtx.datack);

	always_ff @(posedge sys_clk) begin
		if (!resetl)
			dover <= 1'b0;
		else
			dover <= mreq;
	end

	assign mtx.mreq = mreq;
	assign mtx.dover = dover;
	assign mtx.addr = mtxa;
	assign sys.stall = dover && !mtx.datack;

	// Internal instruction for the current state
	always_comb begin
		sys.ins.src = row[5:1];
		sys.ins.half = row[0];
		sys.ins.dst = dst;
		case (state)
			MULT: sys.ins.op = mmult_isa_pkg::IMULTN;
			MAC: sys.ins.op = mmult_isa_pkg::IMACN;
			RES: sys.ins.op = mmult_isa_pkg::RESMAC;
			default: sys.ins.op = mmult_isa_pkg::NOP;
		endcase
	end

	// RESMAC retires only after the last data phase, so idle never requests
	a_idle_mreq: assert property (@(posedge sys_clk) disable iff (!resetl)
		(state == IDLE) |-> !dover);

	// MAC ends at count 1, so 0 means a lost step
	a_mac_count: assert property (@(posedge sys_clk) disable iff (!resetl)
		(state == MAC) |-> (count != 4'd0));

endmodule

//--- hw/matrix_ram.sv
// Single-port matrix RAM with host priority and a waited sequencer data phase
`timescale 1ns/1ps
`include "mmult_consts.svh"

module matrix_ram #(
	parameter int WAIT_CYCLES = 1
) (
	input logic sys_clk,
	input logic resetl,
	input logic host_we,
	input logic host_re,
	input logic [`MMULT_ADDR_W-1:0] host_addr,
	input logic [`MMULT_DATA_W-1:0] host_wdata,
	output logic [`MMULT_DATA_W-1:0] host_rdata,
	mtx_bus_if.ram mtx
);
	localparam int IDX_W = $clog2(`MMULT_MTX_DEPTH);
	// Data phase length counted in sequencer reads
	localparam logic [2:0] ACK_AT = 3'(WAIT_CYCLES + 1);

	logic [`MMULT_DATA_W-1:0] mem [`MMULT_MTX_DEPTH];
	logic [`MMULT_DATA_W-1:0] q;
	logic [2:0] cnt;
	logic host_sel;
	logic seq_rd;
	logic [IDX_W-1:0] idx;

	// Host takes the port, the sequencer waits that cycle out
	assign host_sel = host_we | host_re;
	assign seq_rd = mtx.mreq & ~host_sel;
	// Addresses wrap to the RAM depth
	assign idx = host_sel ? host_addr[IDX_W-1:0] : mtx.addr[IDX_W-1:0];

	always_ff @(posedge sys_clk) begin
		if (host_we)
			mem[idx] <= host_wdata;
		if (host_re || seq_rd)
			q <= mem[idx];
	end

	// Restart the count on every new data phase
	always_ff @(posedge sys_clk) begin
		if (!resetl)
			cnt <= 3'd0;
		else if (!mtx.dover || mtx.datack)
			cnt <= 3'd0;
		else if (seq_rd)
			cnt <= cnt + 3'd1;
	end

	// Acknowledge once enough reads of the held address have gone by
	assign mtx.datack = (cnt == ACK_AT);
	assign mtx.rdata = q;
	assign host_rdata = q;

	// Sequencer keeps the data phase open until its acknowledge
	a_datack_dover: assert property (@(posedge sys_clk) disable iff (!resetl)
		mtx.datack |-> mtx.dover);

endmodule

//--- hw/mac_datapath.sv
// Register file and multiply-accumulate stage driven by internal instructions
`timescale 1ns/1ps
`include "mmult_consts.svh"

module mac_datapath (
	input logic sys_clk,
	input logic resetl,
	input logic rf_we,
	input logic [4:0] rf_addr,
	input logic [`MMULT_DATA_W-1:0] rf_wdata,
	output logic [`MMULT_DATA_W-1:0] rf_rdata,
	mtx_bus_if.dp mtx,
	sys_ins_if.dp sys,
	input logic busy
);
	logic [`MMULT_DATA_W-1:0] rf [`MMULT_REG_COUNT];
	// Execute stage, one step behind issue
	mmult_isa_pkg::sys_op_e ex_op;
	logic [`MMULT_DATA_W-1:0] ex_word;
	logic [4:0] ex_dst;
	logic [`MMULT_DATA_W-1:0] acc;
	logic step;
	logic [15:0] opnd;
	logic signed [`MMULT_DATA_W-1:0] prod;
	logic mult_go;
	logic res_we;

	// Advance whenever the matrix data is not holding us up
	assign step = busy && !sys.stall;
	assign sys.step = step;

	// Row element from the register half picked at issue
	assign opnd = sys.multsel ? ex_word[31:16] : ex_word[15:0];
	assign prod = $signed(opnd) * $signed(mtx.rdata[15:0]);

	// Multiplies complete with datack, RESMAC completes at once
	assign mult_go = mtx.datack &&
		(ex_op == mmult_isa_pkg::IMULTN || ex_op == mmult_isa_pkg::IMACN);
	assign res_we = (ex_op == mmult_isa_pkg::RESMAC);

	always_ff @(posedge sys_clk) begin
		if (!resetl)
			ex_op <= mmult_isa_pkg::NOP;
		else if (step)
			ex_op <= sys.ins.op;
		else if (mult_go || res_we)
			ex_op <= mmult_isa_pkg::NOP;
	end

	always_ff @(posedge sys_clk) begin
		if (step) begin
			ex_word <= rf[sys.ins.src];
			ex_dst <= sys.ins.dst;
		end
		// IMULTN starts a new sum, wrapping at 32 bits
		if (mult_go) begin
			if (ex_op == mmult_isa_pkg::IMULTN)
				acc <= prod;
			else
				acc <= acc + prod;
		end
	end

	// Host write port, result port wins on the same register
	always_ff @(posedge sys_clk) begin
		if (rf_we)
			rf[rf_addr] <= rf_wdata;
		if (res_we)
			rf[ex_dst] <= acc;
	end

	assign rf_rdata = rf[rf_addr];

endmodule

//--- hw/mmult_top.sv
// MMULT coprocessor top: host slave, sequencer, matrix RAM and MAC datapath
`timescale 1ns/1ps
`include "mmult_consts.svh"

module mmult_top #(
	parameter int WAIT_CYCLES = 1
) (
	input logic sys_clk,
	input logic resetl,
	input logic [`MMULT_ADDR_W+1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [`MMULT_DATA_W-1:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [`MMULT_ADDR_W+1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [`MMULT_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic instr_valid,
	input logic [15:0] instr,
	output logic instr_ready,
	output logic busy
);
	logic mtxc_wr;
	logic mtxa_wr;
	logic [`MMULT_DATA_W-1:0] reg_wdata;
	mmult_bus_pkg::mtxc_t mtxc;
	logic [`MMULT_ADDR_W-1:0] mtxa;
	logic host_we;
	logic host_re;
	logic [`MMULT_ADDR_W-1:0] host_addr;
	logic [`MMULT_DATA_W-1:0] host_wdata;
	logic [`MMULT_DATA_W-1:0] host_rdata;
	logic rf_we;
	logic [4:0] rf_addr;
	logic [`MMULT_DATA_W-1:0] rf_wdata;
	logic [`MMULT_DATA_W-1:0] rf_rdata;

	mtx_bus_if mtx_bus ();
	sys_ins_if sys_ins ();

	// One instruction in flight
	assign instr_ready = ~busy;

	mmult_host_regs u_host (
		.sys_clk, .resetl,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.busy, .mtxc_wr, .mtxa_wr, .reg_wdata, .mtxc, .mtxa,
		.host_we, .host_re, .host_addr, .host_wdata, .host_rdata,
		.rf_we, .rf_addr, .rf_wdata, .rf_rdata
	);

	systolic_seq u_seq (
		.sys_clk, .resetl, .instr_valid, .instr, .busy,
		.mtxc_wr, .mtxa_wr, .wdata(reg_wdata), .mtxc, .mtxa,
		.mtx(mtx_bus.seq), .sys(sys_ins.seq)
	);

	matrix_ram #(.WAIT_CYCLES(WAIT_CYCLES)) u_ram (
		.sys_clk, .resetl, .host_we, .host_re, .host_addr, .host_wdata, .host_rdata,
		.mtx(mtx_bus.ram)
	);

	mac_datapath u_dp (
		.sys_clk, .resetl, .rf_we, .rf_addr, .rf_wdata, .rf_rdata,
		.mtx(mtx_bus.dp), .sys(sys_ins.dp), .busy
	);

endmodule

//--- dv/mmult_tb.sv
// Testbench for mmult_top with clock, AXI4-Lite tasks, LFSR, reference model and checks
`timescale 1ns/1ps
`include "mmult_consts.svh"

module mmult_tb;
	localparam int WAIT = 2;
	localparam int AW = `MMULT_ADDR_W + 2;
	localparam int IDX_W = $clog2(`MMULT_MTX_DEPTH);
	localparam int AXI_TMO = 64;
	localparam int RUN_TMO = 2000;
	localparam logic [AW-1:0] MTXC_A = AW'(`MMULT_MTXC_ADDR);
	localparam logic [AW-1:0] MTXA_A = AW'(`MMULT_MTXA_ADDR);
	// Gap between the RAM and register regions
	localparam logic [AW-1:0] UNMAPPED_A = AW'('h600);

	logic sys_clk;
	logic resetl;
	logic [AW-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AW-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic instr_valid;
	logic [15:0] instr;
	logic instr_ready;
	logic busy;

	// Shadow copies of the DUT state
	logic [31:0] model_rf [`MMULT_REG_COUNT];
	logic [31:0] model_ram [`MMULT_MTX_DEPTH];
	mmult_bus_pkg::mtxc_t model_mtxc;
	logic [`MMULT_ADDR_W-1:0] model_mtxa;
	// Pending results as destination and value
	logic [4:0] exp_rd_q [$];
	logic [31:0] exp_val_q [$];
	logic check_pending;
	logic [15:0] lfsr_state;
	int check_count;
	int mismatch_count;
	int timeout_count;

	mmult_top #(.WAIT_CYCLES(WAIT)) dut (.*);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// Galois LFSR with taps 16,14,13,11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hb400;
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [AW-1:0] ram_addr(input logic [IDX_W-1:0] i);
		return AW'(`MMULT_RAM_BASE) + AW'({i, 2'b00});
	endfunction

	function automatic logic [AW-1:0] reg_addr(input logic [4:0] i);
		return AW'(`MMULT_REG_BASE) + AW'({i, 2'b00});
	endfunction

	// Dot product of row halves from rs upward with the strided column
	function automatic logic [31:0] ref_mmult(input logic [4:0] rs,
		output logic [`MMULT_ADDR_W-1:0] next_mtxa);
		int n;
		logic [`MMULT_ADDR_W-1:0] stride;
		logic [`MMULT_ADDR_W-1:0] a;
		logic [4:0] r;
		logic [15:0] row_h;
		logic [15:0] col_h;
		logic signed [31:0] prod;
		logic [31:0] acc;
		n = (model_mtxc.width == 4'd0) ? 16 : int'(model_mtxc.width);
		stride = model_mtxc.addw ? `MMULT_ADDR_W'(n) : `MMULT_ADDR_W'(1);
		a = model_mtxa;
		acc = '0;
		for (int k = 0; k < n; k++) begin
			r = rs + 5'(k / 2);
			row_h = (k % 2 == 1) ? model_rf[r][31:16] : model_rf[r][15:0];
			col_h = model_ram[a[IDX_W-1:0]][15:0];
			prod = $signed(row_h) * $signed(col_h);
			acc = acc + prod;
			a = a + stride;
		end
		next_mtxa = a;
		return acc;
	endfunction

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			mismatch_count++;
			$display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_resp(input string name, input mmult_bus_pkg::axi_resp_e got,
		input mmult_bus_pkg::axi_resp_e exp);
		check_count++;
		if (got !== exp) begin
			mismatch_count++;
			$display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		timeout_count++;
		$display("Timed out waiting for %s", what);
	endtask

	// Address and data together, response taken as soon as it shows
	task automatic axi_write(input logic [AW-1:0] addr, input logic [31:0] data,
		output mmult_bus_pkg::axi_resp_e resp);
		int n;
		@(negedge sys_clk);
		awaddr = addr;
		awvalid = 1'b1;
		wdata = data;
		wstrb = 4'hf;
		wvalid = 1'b1;
		bready = 1'b1;
		n = 0;
		while (!(awready && wready) && n < AXI_TMO) begin
			@(negedge sys_clk);
			n++;
		end
		if (!(awready && wready))
			report_timeout("awready and wready");
		@(negedge sys_clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		n = 0;
		while (!bvalid && n < AXI_TMO) begin
			@(negedge sys_clk);
			n++;
		end
		if (!bvalid)
			report_timeout("bvalid");
		resp = mmult_bus_pkg::axi_resp_e'(bresp);
		@(negedge sys_clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [AW-1:0] addr, output logic [31:0] data,
		output mmult_bus_pkg::axi_resp_e resp);
		int n;
		@(negedge sys_clk);
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		n = 0;
		while (!arready && n < AXI_TMO) begin
			@(negedge sys_clk);
			n++;
		end
		if (!arready)
			report_timeout("arready");
		@(negedge sys_clk);
		arvalid = 1'b0;
		n = 0;
		while (!rvalid && n < AXI_TMO) begin
			@(negedge sys_clk);
			n++;
		end
		if (!rvalid)
			report_timeout("rvalid");
		data = rdata;
		resp = mmult_bus_pkg::axi_resp_e'(rresp);
		@(negedge sys_clk);
		rready = 1'b0;
	endtask

	task automatic write_ok(input logic [AW-1:0] addr, input logic [31:0] data);
		mmult_bus_pkg::axi_resp_e resp;
		axi_write(addr, data, resp);
		check_resp($sformatf("bresp at 0x%03h", addr), resp, mmult_bus_pkg::OKAY);
	endtask

	task automatic read_check(input string name, input logic [AW-1:0] addr,
		input logic [31:0] exp);
		logic [31:0] data;
		mmult_bus_pkg::axi_resp_e resp;
		axi_read(addr, data, resp);
		check_resp({name, " rresp"}, resp, mmult_bus_pkg::OKAY);
		check_word(name, data, exp);
	endtask

	task automatic set_matrix(input logic addw, input logic [3:0] width,
		input logic [IDX_W-1:0] start);
		model_mtxc.addw = addw;
		model_mtxc.width = width;
		model_mtxa = `MMULT_ADDR_W'(start);
		write_ok(MTXC_A, {{(32 - 5){1'b0}}, model_mtxc});
		write_ok(MTXA_A, {{(32 - AW){1'b0}}, model_mtxa, 2'b00});
	endtask

	// Queue the expected result and advance the shadow state
	task automatic expect_mmult(input logic [4:0] rs, input logic [4:0] rd);
		logic [31:0] v;
		logic [`MMULT_ADDR_W-1:0] next_a;
		v = ref_mmult(rs, next_a);
		exp_rd_q.push_back(rd);
		exp_val_q.push_back(v);
		model_rf[rd] = v;
		model_mtxa = next_a;
	endtask

	// Returns on the falling edge after acceptance
	task automatic issue_mmult(input logic [4:0] rs, input logic [4:0] rd);
		mmult_isa_pkg::instr_t ins;
		int n;
		ins.op = mmult_isa_pkg::MMULT;
		ins.rs = rs;
		ins.rd = rd;
		@(negedge sys_clk);
		instr = ins;
		instr_valid = 1'b1;
		n = 0;
		while (!instr_ready && n < RUN_TMO) begin
			@(negedge sys_clk);
			n++;
		end
		if (!instr_ready)
			report_timeout("instr_ready");
		@(negedge sys_clk);
		instr_valid = 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < RUN_TMO) begin
			@(negedge sys_clk);
			n++;
		end
		if (busy)
			report_timeout("busy to fall");
	endtask

	// Hand the queued results to the compare process
	task automatic run_compare();
		int n;
		check_pending = 1'b1;
		n = 0;
		while (check_pending && n < RUN_TMO) begin
			@(negedge sys_clk);
			n++;
		end
		if (check_pending)
			report_timeout("result compare");
	endtask

	// Reads back each destination and MTXA once the sequencer is idle
	initial begin : compare_results
		logic [4:0] r;
		logic [31:0] v;
		logic [31:0] data;
		mmult_bus_pkg::axi_resp_e resp;
		forever begin
			@(negedge sys_clk);
			if (check_pending) begin
				while (exp_rd_q.size() > 0) begin
					r = exp_rd_q.pop_front();
					v = exp_val_q.pop_front();
					axi_read(reg_addr(r), data, resp);
					check_resp("result rresp", resp, mmult_bus_pkg::OKAY);
					check_word($sformatf("r%0d", r), data, v);
				end
				axi_read(MTXA_A, data, resp);
				check_resp("mtxa rresp", resp, mmult_bus_pkg::OKAY);
				check_word("mtxa", data, {{(32 - AW){1'b0}}, model_mtxa, 2'b00});
				check_pending = 1'b0;
			end
		end
	end

	initial begin : stimulus
		mmult_bus_pkg::axi_resp_e resp;
		logic [31:0] data;
		logic [4:0] rs;
		logic [4:0] rd;
		logic [4:0] rd_b;
		logic [IDX_W-1:0] widx;
		resetl = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'h0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		check_pending = 1'b0;
		lfsr_state = 16'd94;
		check_count = 0;
		mismatch_count = 0;
		timeout_count = 0;
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		resetl = 1'b1;

		// Idle after reset
		check_word("busy", 32'(busy), 32'd0);
		check_word("instr_ready", 32'(instr_ready), 32'd1);
		read_check("mtxc after reset", MTXC_A, 32'd0);
		read_check("mtxa after reset", MTXA_A, 32'd0);

		// Random matrix and register contents
		for (int i = 0; i < `MMULT_MTX_DEPTH; i++) begin
			model_ram[i] = rand_bits(32);
			write_ok(ram_addr(IDX_W'(i)), model_ram[i]);
		end
		for (int i = 0; i < `MMULT_REG_COUNT; i++) begin
			model_rf[i] = rand_bits(32);
			write_ok(reg_addr(5'(i)), model_rf[i]);
		end

		// Unit stride, then stride equal to the width
		for (int pass = 0; pass < 6; pass++) begin
			set_matrix(pass >= 3, 4'(rand_bits(4)), IDX_W'(rand_bits(IDX_W)));
			rs = 5'(rand_bits(5));
			rd = 5'(rand_bits(5));
			expect_mmult(rs, rd);
			issue_mmult(rs, rd);
			wait_idle();
			run_compare();
		end

		// Host RAM access refused while the sequencer runs
		set_matrix(1'b0, 4'd0, IDX_W'(rand_bits(IDX_W)));
		rs = 5'(rand_bits(5));
		rd = 5'(rand_bits(5));
		expect_mmult(rs, rd);
		issue_mmult(rs, rd);
		check_word("busy during mmult", 32'(busy), 32'd1);
		widx = IDX_W'(rand_bits(IDX_W));
		axi_write(ram_addr(widx), ~model_ram[widx], resp);
		check_resp("ram write while busy", resp, mmult_bus_pkg::SLVERR);
		axi_read(ram_addr(widx), data, resp);
		check_resp("ram read while busy", resp, mmult_bus_pkg::SLVERR);
		wait_idle();
		run_compare();
		read_check("ram word after refused write", ram_addr(widx), model_ram[widx]);
		axi_write(UNMAPPED_A, 32'h0, resp);
		check_resp("unmapped write", resp, mmult_bus_pkg::SLVERR);
		axi_read(UNMAPPED_A, data, resp);
		check_resp("unmapped read", resp, mmult_bus_pkg::SLVERR);

		// Second MMULT held off until the first retires
		set_matrix(1'b1, 4'(rand_bits(4)), IDX_W'(rand_bits(IDX_W)));
		rs = 5'(rand_bits(5));
		rd = 5'(rand_bits(5));
		expect_mmult(rs, rd);
		issue_mmult(rs, rd);
		check_word("instr_ready while busy", 32'(instr_ready), 32'd0);
		rs = 5'(rand_bits(5));
		rd_b = 5'(rand_bits(5));
		if (rd_b == rd)
			rd_b = rd + 5'd1;
		expect_mmult(rs, rd_b);
		issue_mmult(rs, rd_b);
		wait_idle();
		run_compare();

		$display("Summary: %0d checks, %0d mismatches, %0d timeouts",
			check_count, mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+hw
hw/mmult_isa_pkg.sv
hw/mmult_bus_pkg.sv
hw/mtx_bus_if.sv
hw/sys_ins_if.sv
hw/mmult_host_regs.sv
hw/systolic_seq.sv
hw/matrix_ram.sv
hw/mac_datapath.sv
hw/mmult_top.sv
dv/mmult_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= mmult_tb
FLIST ?= project.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(BUILD_DIR)
